/* Makefile */
# Verilator build of the SHA-512 accelerator testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_hc_sha512
FILELIST  = hc_sha512.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hc_sha512.f */
src/sha512_pkg.sv
src/sha512_core.sv
src/sha512_requestor.sv
src/sha512_csr.sv
src/hc_sha512_top.sv
test/tb_clock_gen.sv
test/tb_hc_sha512.sv

/* src/hc_sha512_top.sv */
// ======================================
// Top level of the SHA-512 hashing accelerator
// The host drives apb_req and reads apb_rsp, all on one clock
// HC_BUFFER_BLOCKS sizes the on-chip message buffer
// ======================================

`timescale 1ns/1ns

module hc_sha512_top #(
  parameter int HC_BUFFER_BLOCKS = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  sha512_pkg::apb_req_t apb_req,
  output sha512_pkg::apb_rsp_t apb_rsp
);
  import sha512_pkg::*;

  localparam int IDX_W = (HC_BUFFER_BLOCKS > 1) ? $clog2(HC_BUFFER_BLOCKS) : 1;

  // CSR block and requestor
  hc_control_t      hc_control;
  logic [IDX_W-1:0] buf_index;
  block_t           buf_block;
  logic             busy;
  logic             done;

  // Requestor and core handshake
  block_t  block;
  logic    block_valid;
  logic    first;
  logic    ready;
  digest_t digest;
  logic    digest_valid;

  sha512_csr #(.HC_BUFFER_BLOCKS(HC_BUFFER_BLOCKS)) csr_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .hc_control   (hc_control),
    .buf_index    (buf_index),
    .buf_block    (buf_block),
    .busy         (busy),
    .done         (done),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  sha512_requestor #(.HC_BUFFER_BLOCKS(HC_BUFFER_BLOCKS)) requestor_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .hc_control   (hc_control),
    .buf_index    (buf_index),
    .buf_block    (buf_block),
    .block        (block),
    .block_valid  (block_valid),
    .first        (first),
    .ready        (ready),
    .digest_valid (digest_valid),
    .busy         (busy),
    .done         (done)
  );

  sha512_core core_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .block        (block),
    .block_valid  (block_valid),
    .first        (first),
    .ready        (ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

endmodule

/* src/sha512_core.sv */
// ======================================
// Iterative SHA-512 compression engine
// Takes one padded block on a valid/ready handshake and runs one
// round per clock, then adds the result into the chained hash
// first selects the initial hash value instead of the held digest
// ======================================

`timescale 1ns/1ns

module sha512_core (
  input  logic                clk,
  input  logic                arst_n,
  input  sha512_pkg::block_t  block,
  input  logic                block_valid,
  input  logic                first,
  output logic                ready,
  output sha512_pkg::digest_t digest,
  output logic                digest_valid
);
  import sha512_pkg::*;

  // Initial hash value from FIPS 180-4
  localparam word_t IV [8] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  // Round constants, one per round
  localparam word_t K [80] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  typedef enum logic [1:0] {ST_IDLE, ST_ROUNDS, ST_FINAL} core_state_t;

  core_state_t state;
  logic [6:0]  round;
  logic        accept;

  // Rolling schedule, w[0] is the word used by the current round
  word_t w [16];
  // Working variables a to h
  word_t wv [8];
  // Chained hash state
  word_t hash [8];

  // Round inputs, taken from the new block while idle
  word_t src_w [16];
  word_t src_v [8];
  word_t w_next [16];
  word_t v_next [8];
  word_t t1;
  word_t t2;

  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

  function automatic word_t big_s0(word_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic word_t big_s1(word_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  function automatic word_t small_s0(word_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic word_t small_s1(word_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  assign ready  = (state == ST_IDLE);
  assign accept = block_valid && ready;
  assign digest = {hash[0], hash[1], hash[2], hash[3], hash[4], hash[5], hash[6], hash[7]};

  // Round 0 runs on the accepting edge, straight from the incoming block
  always_comb begin : round_source
    for (int i = 0; i < 16; i++) begin
      src_w[i] = (state == ST_IDLE) ? block[1023 - 64*i -: 64] : w[i];
    end
    for (int i = 0; i < 8; i++) begin
      if (state == ST_IDLE) begin
        src_v[i] = first ? IV[i] : hash[i];
      end else begin
        src_v[i] = wv[i];
      end
    end
  end

  // One compression round and one schedule step
  always_comb begin : round_logic
    t1 = src_v[7] + big_s1(src_v[4]) + ((src_v[4] & src_v[5]) ^ (~src_v[4] & src_v[6]))
         + K[round] + src_w[0];
    t2 = big_s0(src_v[0])
         + ((src_v[0] & src_v[1]) ^ (src_v[0] & src_v[2]) ^ (src_v[1] & src_v[2]));
    v_next[0] = t1 + t2;
    v_next[1] = src_v[0];
    v_next[2] = src_v[1];
    v_next[3] = src_v[2];
    v_next[4] = src_v[3] + t1;
    v_next[5] = src_v[4];
    v_next[6] = src_v[5];
    v_next[7] = src_v[6];
    // The schedule shifts down and appends W[t+16]
    for (int i = 0; i < 15; i++) begin
      w_next[i] = src_w[i + 1];
    end
    w_next[15] = small_s1(src_w[14]) + src_w[9] + small_s0(src_w[1]) + src_w[0];
  end

  // ======================================
  // Sequencing
  // ======================================

  // Accept edge runs round 0, ST_ROUNDS runs rounds 1 to 79
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= ST_IDLE;
      round        <= '0;
      digest_valid <= 1'b0;
    end else begin
      digest_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_ROUNDS;
            round <= 7'd1;
          end
        end
        ST_ROUNDS: begin
          if (round == 7'd79) begin
            state <= ST_FINAL;
          end else begin
            round <= round + 7'd1;
          end
        end
        ST_FINAL: begin
          // Final add lands this edge, so the pulse lines up with the new digest
          state        <= ST_IDLE;
          round        <= '0;
          digest_valid <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept || state == ST_ROUNDS) begin
      w  <= w_next;
      wv <= v_next;
    end
    // A first block restarts the chain from the initial value
    if (accept && first) begin
      hash <= IV;
    end
    if (state == ST_FINAL) begin
      for (int i = 0; i < 8; i++) begin
        hash[i] <= hash[i] + wv[i];
      end
    end
  end

  // Every accepted block returns its digest 81 cycles later with the core ready again
  a_block_latency: assert property (@(posedge clk) disable iff (!arst_n)
    accept |-> ##81 (digest_valid && ready));

endmodule

/* src/sha512_csr.sv */
// ======================================
// APB register block of the SHA-512 accelerator
// Holds control and status, the message buffer and the captured digest
// Software fills the buffer, writes CTRL to start, polls STATUS
// and reads DIGEST when done is set
// ======================================

`timescale 1ns/1ns

module sha512_csr #(
  parameter int HC_BUFFER_BLOCKS = 4,
  localparam int IDX_W = (HC_BUFFER_BLOCKS > 1) ? $clog2(HC_BUFFER_BLOCKS) : 1
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  sha512_pkg::apb_req_t    apb_req,
  output sha512_pkg::apb_rsp_t    apb_rsp,
  output sha512_pkg::hc_control_t hc_control,
  input  logic [IDX_W-1:0]        buf_index,
  output sha512_pkg::block_t      buf_block,
  input  logic                    busy,
  input  logic                    done,
  input  sha512_pkg::digest_t     digest,
  input  logic                    digest_valid
);
  import sha512_pkg::*;

  // Each block takes 32 words of 4 bytes
  localparam int BUF_BYTES = HC_BUFFER_BLOCKS * 128;

  block_t    buf_mem [HC_BUFFER_BLOCKS];
  digest_t   digest_q;
  logic      error_q;
  logic [7:0] ctrl_blocks;

  logic       wr;
  logic       is_ctrl;
  logic       is_digest;
  logic       is_buf;
  apb_addr_t  buf_off;
  logic [IDX_W-1:0] buf_blk;
  logic [4:0] buf_word;
  logic [3:0] dig_word;
  logic [7:0] wr_blocks;
  logic       start_req;
  logic       start_err;
  logic       start_ok;
  logic       buf_wr;
  logic       buf_wr_err;
  apb_data_t  rd_data;

  // ======================================
  // Address decode
  // ======================================

  // Writes take effect in the access cycle, pready never drops
  assign wr        = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign is_ctrl   = (apb_req.paddr == REG_CTRL);
  assign is_digest = (apb_req.paddr[11:6] == REG_DIGEST[11:6]);
  assign dig_word  = apb_req.paddr[5:2];

  // Buffer word n of block b lives at REG_BUFFER + 128*b + 4*n
  assign buf_off  = apb_req.paddr - REG_BUFFER;
  assign is_buf   = (apb_req.paddr >= REG_BUFFER) && (int'(buf_off) < BUF_BYTES);
  assign buf_blk  = buf_off[7 +: IDX_W];
  assign buf_word = buf_off[6:2];

  // Start checks, a rejected start never reaches the requestor
  assign wr_blocks  = apb_req.pwdata[15:8];
  assign start_req  = wr && is_ctrl && apb_req.pwdata[0];
  assign start_err  = start_req && (busy || wr_blocks == 8'd0
                                    || int'(wr_blocks) > HC_BUFFER_BLOCKS);
  assign start_ok   = start_req && !start_err;
  assign buf_wr_err = wr && is_buf && busy;
  assign buf_wr     = wr && is_buf && !busy;

  assign hc_control.start      = start_ok;
  assign hc_control.num_blocks = wr_blocks;

  // ======================================
  // Registers and buffer
  // ======================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      error_q     <= 1'b0;
      ctrl_blocks <= '0;
    end else begin
      // Only a later legal start clears the error flag
      if (start_err) begin
        error_q <= 1'b1;
      end else if (start_ok) begin
        error_q <= 1'b0;
      end
      if (wr && is_ctrl && !start_err) begin
        ctrl_blocks <= wr_blocks;
      end
    end
  end

  // Word 0 of a block is its top 32 bits, hence the inverted word index
  always_ff @(posedge clk) begin
    if (buf_wr) begin
      buf_mem[buf_blk][{~buf_word, 5'd0} +: 32] <= apb_req.pwdata;
    end
    if (digest_valid) begin
      digest_q <= digest;
    end
    // Registered read port toward the requestor
    buf_block <= buf_mem[buf_index];
  end

  // ======================================
  // Read path
  // ======================================

  always_comb begin : read_mux
    rd_data = '0;
    if (is_buf) begin
      rd_data = buf_mem[buf_blk][{~buf_word, 5'd0} +: 32];
    end else if (is_digest) begin
      rd_data = digest_q[{~dig_word, 5'd0} +: 32];
    end else if (is_ctrl) begin
      rd_data = {16'd0, ctrl_blocks, 8'd0};
    end else if (apb_req.paddr == REG_STATUS) begin
      rd_data = {29'd0, error_q, done, busy};
    end
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = start_err || buf_wr_err;

  // Every access cycle follows a setup cycle with psel already high
  a_apb_setup: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(apb_req.penable) |-> (apb_req.psel && $past(apb_req.psel)));

endmodule

/* src/sha512_pkg.sv */
// ======================================
// Shared types and register map of the SHA-512 accelerator
// Imported by the core, the requestor, the CSR block and the top
// Register offsets are APB byte addresses in a 4 KB window
// ======================================

package sha512_pkg;

  // One SHA-512 working word
  typedef logic [63:0] word_t;

  // One padded message block, word 0 sits in the top 64 bits
  typedef logic [1023:0] block_t;

  // Hash state, word a sits in the top 64 bits
  typedef logic [511:0] digest_t;

  typedef logic [31:0] apb_data_t;
  typedef logic [11:0] apb_addr_t;

  // Request side of the APB link, driven by the host
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Response side of the APB link, driven by the CSR block
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Run request from the CSR block, start is a single cycle pulse
  typedef struct packed {
    logic       start;
    logic [7:0] num_blocks;
  } hc_control_t;

  // Register map
  localparam apb_addr_t REG_CTRL   = 12'h000;
  localparam apb_addr_t REG_STATUS = 12'h004;
  localparam apb_addr_t REG_DIGEST = 12'h040;
  localparam apb_addr_t REG_BUFFER = 12'h400;

endpackage

/* src/sha512_requestor.sv */
// ======================================
// Block sequencer between the message buffer and the core
// On start it walks buffer entries 0 to num_blocks-1, presents each
// one to the core and waits for its digest before the next
// ======================================

`timescale 1ns/1ns

module sha512_requestor #(
  parameter int HC_BUFFER_BLOCKS = 4,
  localparam int IDX_W = (HC_BUFFER_BLOCKS > 1) ? $clog2(HC_BUFFER_BLOCKS) : 1
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  sha512_pkg::hc_control_t hc_control,
  output logic [IDX_W-1:0]        buf_index,
  input  sha512_pkg::block_t      buf_block,
  output sha512_pkg::block_t      block,
  output logic                    block_valid,
  output logic                    first,
  input  logic                    ready,
  input  logic                    digest_valid,
  output logic                    busy,
  output logic                    done
);

  typedef enum logic [1:0] {RQ_IDLE, RQ_FETCH, RQ_PRESENT, RQ_WAIT_DIGEST} rq_state_t;

  rq_state_t        state;
  // Index of the final block of the run
  logic [IDX_W-1:0] last_idx;

  // The buffer output holds steady while the index does, so it feeds the core as is
  assign block       = buf_block;
  assign block_valid = (state == RQ_PRESENT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= RQ_IDLE;
      buf_index <= '0;
      last_idx  <= '0;
      first     <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      case (state)
        RQ_IDLE: begin
          // The CSR block only pulses start for a legal block count
          if (hc_control.start) begin
            state     <= RQ_FETCH;
            buf_index <= '0;
            last_idx  <= hc_control.num_blocks[IDX_W-1:0] - 1'b1;
            first     <= 1'b1;
            busy      <= 1'b1;
            done      <= 1'b0;
          end
        end
        RQ_FETCH: begin
          // One cycle for the buffer read of the new index
          state <= RQ_PRESENT;
        end
        RQ_PRESENT: begin
          if (ready) begin
            state <= RQ_WAIT_DIGEST;
            first <= 1'b0;
          end
        end
        RQ_WAIT_DIGEST: begin
          if (digest_valid) begin
            if (buf_index == last_idx) begin
              state <= RQ_IDLE;
              busy  <= 1'b0;
              done  <= 1'b1;
            end else begin
              buf_index <= buf_index + 1'b1;
              state     <= RQ_FETCH;
            end
          end
        end
        default: state <= RQ_IDLE;
      endcase
    end
  end

  // A presented block stays put until the core takes it, buffer writes included
  a_block_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (block_valid && !ready) |=> (block_valid && $stable(block)));

endmodule

/* test/tb_clock_gen.sv */
// ======================================
// Clock and reset source for the testbench
// clk has an 8 ns period, arst_n is held low for 3 cycles
// ======================================

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release lands on a rising edge, like any other driven input
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

/* test/tb_hc_sha512.sv */
// ======================================
// Testbench of the SHA-512 accelerator
// Drives the APB port, runs a table of known SHA-512 vectors and
// checks buffer readback and the error responses of the CSR block
// ======================================

`timescale 1ns/1ns

module tb_hc_sha512;
  import sha512_pkg::*;

  localparam int BUF_BLOCKS      = 4;
  localparam int NUM_TESTS       = 4;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 2000;

  logic       clk;
  logic       arst_n;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  int         errors;
  int         checks;
  logic [31:0] lcg_state;

  // ======================================
  // Test table, one row per run
  // ======================================
  string   test_name    [NUM_TESTS];
  string   test_msg     [NUM_TESTS];
  int      test_nblk    [NUM_TESTS];
  logic    test_disturb [NUM_TESTS];
  digest_t test_digest  [NUM_TESTS];

  tb_clock_gen clock_gen_i (.clk(clk), .arst_n(arst_n));

  hc_sha512_top #(.HC_BUFFER_BLOCKS(BUF_BLOCKS)) hc_sha512_top_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Builds block idx of the message padded out to nblk blocks
  // Bytes follow the message, then 0x80, zeros and a 128-bit bit length
  function automatic block_t pad_block(string msg, int nblk, int idx);
    block_t       blk;
    int           pos;
    logic [127:0] bit_len;
    blk     = '0;
    bit_len = 128'(msg.len()) * 128'd8;
    for (int b = 0; b < 128; b++) begin
      pos = idx * 128 + b;
      if (pos < msg.len()) begin
        blk[1023 - 8*b -: 8] = msg[pos];
      end else if (pos == msg.len()) begin
        blk[1023 - 8*b -: 8] = 8'h80;
      end else if (pos >= nblk * 128 - 16) begin
        blk[1023 - 8*b -: 8] = bit_len[8 * (nblk * 128 - 1 - pos) +: 8];
      end
    end
    return blk;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Setup cycle, then access cycle, response sampled mid access
  task automatic apb_write(apb_addr_t addr, apb_data_t data, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    err = apb_rsp.pslverr;
    // The slave never stretches a transfer
    check_value($sformatf("write %h pready", addr), 32'd1, 32'(apb_rsp.pready));
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_read(apb_addr_t addr, output apb_data_t data);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    check_value($sformatf("read %h pready", addr), 32'd1, 32'(apb_rsp.pready));
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  // Published SHA-512 vectors, the last row repeats abc after the chained run
  task automatic load_table();
    test_name[0] = "abc";
    test_msg[0]  = "abc";
    test_nblk[0] = 1;
    test_name[1] = "empty";
    test_msg[1]  = "";
    test_nblk[1] = 1;
    test_name[2] = "msg896";
    test_msg[2]  = {"abcdefghbcdefghicdefghijdefghijkefghijklfghijklmghijklmn",
                    "hijklmnoijklmnopjklmnopqklmnopqrlmnopqrsmnopqrstnopqrstu"};
    test_nblk[2] = 2;
    test_name[3] = "abc_again";
    test_msg[3]  = "abc";
    test_nblk[3] = 1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_disturb[t] = (t == 2);
    end
    test_digest[0] = {64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2,
                      64'h0a9eeee64b55d39a, 64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd,
                      64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
    test_digest[1] = {64'hcf83e1357eefb8bd, 64'hf1542850d66d8007, 64'hd620e4050b5715dc,
                      64'h83f4a921d36ce9ce, 64'h47d0d13c5d85f2b0, 64'hff8318d2877eec2f,
                      64'h63b931bd47417a81, 64'ha538327af927da3e};
    test_digest[2] = {64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1,
                      64'h7299aeadb6889018, 64'h501d289e4900f7e4, 64'h331b99dec4b5433a,
                      64'hc7d329eeb6dd2654, 64'h5e96e55b874be909};
    test_digest[3] = test_digest[0];
  endtask

  task automatic buffer_readback();
    apb_data_t vals [BUF_BLOCKS*32];
    apb_data_t data;
    logic      err;
    for (int i = 0; i < BUF_BLOCKS * 32; i++) begin
      lcg_state = lcg_next(lcg_state);
      vals[i]   = lcg_state;
      apb_write(REG_BUFFER + apb_addr_t'(4 * i), vals[i], err);
      check_value($sformatf("readback write %0d pslverr", i), 32'd0, 32'(err));
    end
    for (int i = 0; i < BUF_BLOCKS * 32; i++) begin
      apb_read(REG_BUFFER + apb_addr_t'(4 * i), data);
      check_value($sformatf("readback word %0d", i), vals[i], data);
    end
  endtask

  // Illegal block counts are refused, flagged in STATUS, and never start a run
  task automatic bad_start_checks();
    int        counts [2];
    apb_data_t status;
    logic      err;
    counts[0] = 0;
    counts[1] = BUF_BLOCKS + 1;
    for (int i = 0; i < 2; i++) begin
      apb_write(REG_CTRL, {16'd0, 8'(counts[i]), 8'h01}, err);
      check_value($sformatf("bad start %0d pslverr", counts[i]), 32'd1, 32'(err));
      apb_read(REG_STATUS, status);
      check_value($sformatf("bad start %0d error,busy", counts[i]), 32'd2,
                  32'({status[2], status[0]}));
    end
  endtask

  task automatic run_row(int t);
    block_t    blk;
    apb_data_t data;
    apb_data_t status;
    logic      err;
    for (int b = 0; b < test_nblk[t]; b++) begin
      blk = pad_block(test_msg[t], test_nblk[t], b);
      for (int w = 0; w < 32; w++) begin
        apb_write(REG_BUFFER + apb_addr_t'(128 * b + 4 * w), blk[1023 - 32*w -: 32], err);
      end
    end
    apb_write(REG_CTRL, {16'd0, 8'(test_nblk[t]), 8'h01}, err);
    check_value({test_name[t], " start pslverr"}, 32'd0, 32'(err));
    if (test_disturb[t]) begin
      // Both are refused mid run and must leave the digest untouched
      apb_write(REG_CTRL, {16'd0, 8'd1, 8'h01}, err);
      check_value({test_name[t], " busy start pslverr"}, 32'd1, 32'(err));
      // Block 1 is not fetched yet, so a write that got through would change the digest
      lcg_state = lcg_next(lcg_state);
      apb_write(REG_BUFFER + 12'h080, lcg_state, err);
      check_value({test_name[t], " busy buffer pslverr"}, 32'd1, 32'(err));
    end
    do begin
      apb_read(REG_STATUS, status);
    end while (status[1] == 1'b0);
    // A busy start leaves the error flag set, a legal start clears it
    check_value({test_name[t], " status"}, {29'd0, test_disturb[t], 2'b10}, status);
    for (int k = 0; k < 16; k++) begin
      apb_read(REG_DIGEST + apb_addr_t'(4 * k), data);
      check_value($sformatf("%s digest[%0d]", test_name[t], k),
                  test_digest[t][511 - 32*k -: 32], data);
    end
  endtask

  // ======================================
  // Main sequence and watchdog
  // ======================================
  initial begin : main_seq
    apb_req   = '0;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'hd862;
    load_table();
    @(posedge arst_n);
    repeat (2) @(posedge clk);
    buffer_readback();
    bad_start_checks();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_row(t);
    end
    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Summary: %0d errors in %0d checks", errors, checks);
    $display("Test failures found");
    $finish;
  end

endmodule
